// File: logic/capture_params.svh
`ifndef CAPTURE_PARAMS_SVH
`define CAPTURE_PARAMS_SVH

// ------------------------------------------------
// Antenna sampling
// ------------------------------------------------
`define AXNUM 24           // Antennas, one bit each per sample

// ------------------------------------------------
// Buffering
// ------------------------------------------------
`define SFIFO_DEPTH 8      // Captured samples
`define CFIFO_DEPTH 4      // Pending memory commands

// ------------------------------------------------
// Memory controller
// ------------------------------------------------
`define MCB_ABITS 19       // 32-bit word address

// Fake-data LFSR start value
`define LFSR_SEED 24'h000001

`endif

// File: logic/capture_pkg.sv
`default_nettype none

`include "capture_params.svh"

package capture_pkg;

   // ------------------------------------------------
   // Antenna samples
   // ------------------------------------------------
   typedef logic [`AXNUM-1:0] ax_sample_t;   // One bit per antenna

   // Debug source pattern
   typedef enum logic [1:0] {
      FAKE_LFSR  = 2'd0,   // Pseudo-random
      FAKE_SHIFT = 2'd1,   // Walking one
      FAKE_COUNT = 2'd2    // Binary counter
   } fake_mode_t;

   // Feedback taps for x^24+x^23+x^22+x^17+1
   // Bits 23, 22, 21 and 16 of the current value
   localparam ax_sample_t LFSR_TAPS = 24'hE1_0000;

endpackage

`default_nettype wire

// File: logic/mcb_pkg.sv
`default_nettype none

`include "capture_params.svh"

package mcb_pkg;

   // One memory write request, as queued ahead of the controller
   typedef struct packed {
      logic                  wr;    // Always a write here
      logic [`MCB_ABITS-1:0] adr;   // Word address
      logic [31:0]           dat;   // Packed sample bytes
   } mcb_cmd_t;

   // Scheduler status, debug only
   typedef enum logic [1:0] {
      SCH_IDLE  = 2'd0,   // Nothing pending
      SCH_PACK  = 2'd1,   // Partial word held
      SCH_STALL = 2'd2    // Command queue full
   } sched_state_t;

endpackage

`default_nettype wire

// File: logic/mcb_if.sv
`default_nettype none

`include "capture_params.svh"

// Command port of the memory controller block
// ce is the valid, rdy the ready
interface mcb_if;
   logic                  ce;    // Command valid
   logic                  wr;    // Write strobe
   logic [`MCB_ABITS-1:0] adr;   // Word address
   logic [31:0]           dat;   // Write data
   logic                  rdy;   // Controller can take a command

   // Issuing side
   modport scheduler (output ce, output wr, output adr, output dat, input rdy);

   // Receiving side
   modport controller (input ce, input wr, input adr, input dat, output rdy);

endinterface

`default_nettype wire

// File: logic/fake_antenna.sv
`default_nettype none

`include "capture_params.svh"

module fake_antenna import capture_pkg::*; (
   input  wire        clk_e,
   input  wire        rst_i,
   input  wire        enable_i,   // Step once per enabled cycle
   input  fake_mode_t mode_i,
   output ax_sample_t data_o
);

   ax_sample_t state_q;   // Current pattern value
   ax_sample_t step_val;  // Value after one step
   ax_sample_t start_val; // Reset value for this mode
   logic       feedback;  // LFSR input bit

   // ------------------------------------------------
   // Next value and start value per mode
   // ------------------------------------------------
   assign feedback = ^(state_q & LFSR_TAPS);

   always_comb begin
      case (mode_i)
         FAKE_SHIFT: begin
            step_val  = {state_q[`AXNUM-2:0], state_q[`AXNUM-1]};  // Rotate left
            start_val = ax_sample_t'(1);                         // Single one in bit 0
         end
         FAKE_COUNT: begin
            step_val  = state_q + ax_sample_t'(1);
            start_val = '0;
         end
         default: begin
            // Fibonacci shift, new bit enters at the bottom
            step_val  = {state_q[`AXNUM-2:0], feedback};
            start_val = `LFSR_SEED;
         end
      endcase
   end

   // ------------------------------------------------
   // Pattern register
   // ------------------------------------------------
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         state_q <= start_val;   // Mode sampled during reset
      end else if (enable_i) begin
         state_q <= step_val;
      end
   end

   // Value before the step, so the first sample is the start value
   assign data_o = state_q;

endmodule

`default_nettype wire

// File: logic/antenna_capture.sv
`default_nettype none

module antenna_capture import capture_pkg::*; (
   input  wire        clk_e,
   input  wire        rst_i,
   input  wire        aq_ce_i,      // Acquisition enable
   input  wire        vx_ce_i,      // Visibility enable
   input  wire        aq_debug_i,   // Use fake data
   input  wire        aq_shift_i,   // Fake walking one
   input  wire        aq_count_i,   // Fake counter
   input  ax_sample_t ax_data_i,
   output ax_sample_t ax_data_o,
   output logic       aq_valid_o
);

   logic       cap_en;     // Either enable
   logic       fake_en;    // Step the generator
   fake_mode_t fake_mode;
   ax_sample_t fake_data;
   ax_sample_t src_data;   // Real or fake, before the register

   assign cap_en  = aq_ce_i | vx_ce_i;
   assign fake_en = cap_en & aq_debug_i;   // Generator idle outside debug

   // Shift wins over count, LFSR otherwise
   always_comb begin
      if (aq_shift_i) fake_mode = FAKE_SHIFT;
      else if (aq_count_i) fake_mode = FAKE_COUNT;
      else fake_mode = FAKE_LFSR;
   end

   fake_antenna fake_antenna_inst (
      .clk_e    (clk_e),
      .rst_i    (rst_i),
      .enable_i (fake_en),
      .mode_i   (fake_mode),
      .data_o   (fake_data)
   );

   assign src_data = aq_debug_i ? fake_data : ax_data_i;

   // ------------------------------------------------
   // Capture register, one cycle of latency
   // ------------------------------------------------
   always_ff @(posedge clk_e) begin
      if (rst_i) aq_valid_o <= 1'b0;
      else aq_valid_o <= cap_en;
   end

   always_ff @(posedge clk_e) begin
      if (cap_en) ax_data_o <= src_data;   // Held between samples
   end

endmodule

`default_nettype wire

// File: logic/stream_fifo.sv
`default_nettype none

module stream_fifo #(
   parameter type T     = logic,
   parameter int  DEPTH = 4
) (
   input  wire  clk_e,
   input  wire  rst_i,
   input  wire  in_valid_i,
   input  T     in_data_i,
   output logic in_ready_o,
   output logic out_valid_o,
   output T     out_data_o,
   input  wire  out_ready_i
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;   // Pointer width
   localparam int CW = $clog2(DEPTH + 1);                 // Count width

   T               mem [DEPTH];
   logic [AW-1:0]  wr_ptr_q;
   logic [AW-1:0]  rd_ptr_q;
   logic [CW-1:0]  count_q;
   logic           do_wr;
   logic           do_rd;

   // Wraps at DEPTH, which need not be a power of two
   function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
      if (ptr == AW'(DEPTH - 1)) return '0;
      return ptr + AW'(1);
   endfunction

   assign in_ready_o  = (count_q != CW'(DEPTH));   // Not full
   assign out_valid_o = (count_q != '0);           // Not empty
   assign out_data_o  = mem[rd_ptr_q];

   assign do_wr = in_valid_i & in_ready_o;
   assign do_rd = out_valid_o & out_ready_i;

   // ------------------------------------------------
   // Pointers and fill level
   // ------------------------------------------------
   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_wr) wr_ptr_q <= ptr_next(wr_ptr_q);
         if (do_rd) rd_ptr_q <= ptr_next(rd_ptr_q);
         case ({do_wr, do_rd})
            2'b10:   count_q <= count_q + CW'(1);
            2'b01:   count_q <= count_q - CW'(1);
            default: count_q <= count_q;   // Both or neither
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_e) begin
      if (do_wr) mem[wr_ptr_q] <= in_data_i;
   end

endmodule

`default_nettype wire

// File: logic/block_scheduler.sv
`default_nettype none

`include "capture_params.svh"

module block_scheduler import capture_pkg::*; import mcb_pkg::*; (
   input  wire          clk_e,
   input  wire          rst_i,
   input  wire          s_valid_i,
   input  ax_sample_t   s_data_i,
   output logic         s_ready_o,
   mcb_if.scheduler     mcb,
   output sched_state_t tart_state_o
);

   localparam int SBYTES = `AXNUM / 8;   // Bytes per sample

   logic [55:0]           acc_q;     // Up to 7 pending bytes, oldest at the bottom
   logic [2:0]            cnt_q;     // Pending byte count
   logic [55:0]           ins_acc;   // Accumulator with the new sample placed
   logic [`MCB_ABITS-1:0] adr_q;     // Next word address
   logic                  take;      // Sample accepted
   logic                  emit;      // Word pushed to the queue
   mcb_cmd_t              cmd_in;
   logic                  cmd_in_valid;
   logic                  cmd_in_ready;
   mcb_cmd_t              cmd_out;

   // ------------------------------------------------
   // Byte accumulator
   // ------------------------------------------------
   assign s_ready_o    = (cnt_q < 3'd4) & cmd_in_ready;   // Room for 3 more bytes
   assign take         = s_valid_i & s_ready_o;
   assign cmd_in_valid = (cnt_q >= 3'd4);                 // Full word ready
   assign emit         = cmd_in_valid & cmd_in_ready;

   // New bytes go just above the pending ones, low byte first
   always_comb begin
      ins_acc = acc_q;
      for (int i = 0; i < SBYTES; i++) begin
         ins_acc[8*(cnt_q[1:0]+i) +: 8] = s_data_i[8*i +: 8];
      end
   end

   always_ff @(posedge clk_e) begin
      if (rst_i) begin
         cnt_q <= '0;
         adr_q <= '0;
      end else if (emit) begin
         cnt_q <= cnt_q - 3'd4;
         adr_q <= adr_q + `MCB_ABITS'(1);   // Wraps at the top of memory
      end else if (take) begin
         cnt_q <= cnt_q + 3'(SBYTES);
      end
   end

   // Bytes above cnt_q are don't-care
   always_ff @(posedge clk_e) begin
      if (emit) acc_q <= acc_q >> 32;   // Drop the word just sent
      else if (take) acc_q <= ins_acc;
   end

   // ------------------------------------------------
   // Command queue towards the controller
   // ------------------------------------------------
   assign cmd_in.wr  = 1'b1;
   assign cmd_in.adr = adr_q;
   assign cmd_in.dat = acc_q[31:0];

   stream_fifo #(
      .T     (mcb_cmd_t),
      .DEPTH (`CFIFO_DEPTH)
   ) cmd_fifo_inst (
      .clk_e       (clk_e),
      .rst_i       (rst_i),
      .in_valid_i  (cmd_in_valid),
      .in_data_i   (cmd_in),
      .in_ready_o  (cmd_in_ready),
      .out_valid_o (mcb.ce),
      .out_data_o  (cmd_out),
      .out_ready_i (mcb.rdy)
   );

   assign mcb.wr  = cmd_out.wr;
   assign mcb.adr = cmd_out.adr;
   assign mcb.dat = cmd_out.dat;

   // Status, a full queue outranks a partial word
   always_comb begin
      if (!cmd_in_ready) tart_state_o = SCH_STALL;
      else if (cnt_q != '0) tart_state_o = SCH_PACK;
      else tart_state_o = SCH_IDLE;
   end

endmodule

`default_nettype wire

// File: logic/capture_top.sv
`default_nettype none

`include "capture_params.svh"

module capture_top import capture_pkg::*; import mcb_pkg::*; (
   input  wire                   clk_e,
   input  wire                   rst_i,
   // Antenna side
   input  wire                   aq_ce_i,
   input  wire                   vx_ce_i,
   input  wire                   aq_debug_i,
   input  wire                   aq_shift_i,
   input  wire                   aq_count_i,
   input  ax_sample_t            ax_data_i,
   output ax_sample_t            ax_data_o,
   output logic                  aq_valid_o,
   // Memory controller command port
   output logic                  mcb_ce_o,
   output logic                  mcb_wr_o,
   output logic [`MCB_ABITS-1:0] mcb_adr_o,
   output logic [31:0]           mcb_dat_o,
   input  wire                   mcb_rdy_i,
   // Status
   output logic                  overflow_o,
   output sched_state_t          tart_state_o
);

   ax_sample_t fifo_data;     // Sample FIFO head
   logic       fifo_valid;
   logic       fifo_ready;    // Scheduler taking a sample
   logic       sfifo_ready;   // Sample FIFO has room

   mcb_if mcb_bus ();

   // ------------------------------------------------
   // Capture, buffering, scheduling
   // ------------------------------------------------
   antenna_capture capture_inst (
      .clk_e      (clk_e),
      .rst_i      (rst_i),
      .aq_ce_i    (aq_ce_i),
      .vx_ce_i    (vx_ce_i),
      .aq_debug_i (aq_debug_i),
      .aq_shift_i (aq_shift_i),
      .aq_count_i (aq_count_i),
      .ax_data_i  (ax_data_i),
      .ax_data_o  (ax_data_o),
      .aq_valid_o (aq_valid_o)
   );

   stream_fifo #(.T(ax_sample_t), .DEPTH(`SFIFO_DEPTH)) sample_fifo_inst (
      .clk_e       (clk_e),
      .rst_i       (rst_i),
      .in_valid_i  (aq_valid_o),
      .in_data_i   (ax_data_o),
      .in_ready_o  (sfifo_ready),
      .out_valid_o (fifo_valid),
      .out_data_o  (fifo_data),
      .out_ready_i (fifo_ready)
   );

   block_scheduler scheduler_inst (
      .clk_e        (clk_e),
      .rst_i        (rst_i),
      .s_valid_i    (fifo_valid),
      .s_data_i     (fifo_data),
      .s_ready_o    (fifo_ready),
      .mcb          (mcb_bus.scheduler),
      .tart_state_o (tart_state_o)
   );

   // Controller side of the command port
   assign mcb_ce_o    = mcb_bus.ce;
   assign mcb_wr_o    = mcb_bus.wr;
   assign mcb_adr_o   = mcb_bus.adr;
   assign mcb_dat_o   = mcb_bus.dat;
   assign mcb_bus.rdy = mcb_rdy_i;

   // Sticky until reset, a sample was lost at the full FIFO
   always_ff @(posedge clk_e) begin
      if (rst_i) overflow_o <= 1'b0;
      else if (aq_valid_o && !sfifo_ready) overflow_o <= 1'b1;
   end

endmodule

`default_nettype wire

// File: testbench/capture_chk.sv
`default_nettype none

`include "capture_params.svh"

module capture_chk import mcb_pkg::*; (
   input wire                  clk_e,
   input wire                  rst_i,
   input wire                  aq_valid_i,
   input wire                  mcb_ce_i,
   input wire                  mcb_wr_i,
   input wire [`MCB_ABITS-1:0] mcb_adr_i,
   input wire [31:0]           mcb_dat_i,
   input wire                  mcb_rdy_i,
   input wire                  overflow_i,
   input sched_state_t         state_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;   // Failed assertions so far

   // ------------------------------------------------
   // Memory command port
   // ------------------------------------------------
   // A stalled command holds until the controller takes it
   property cmd_held_p;
      @(posedge clk_e) disable iff (rst_i)
         (mcb_ce_i && !mcb_rdy_i) |=>
            (mcb_ce_i && $stable(mcb_wr_i) && $stable(mcb_adr_i) && $stable(mcb_dat_i));
   endproperty

   cmd_held_a: assert property (cmd_held_p)
      else begin
         $error("memory command changed before it was accepted");
         fail_cnt++;
      end

   cmd_write_a: assert property (@(posedge clk_e) disable iff (rst_i) mcb_ce_i |-> mcb_wr_i)
      else begin
         $error("memory command issued without the write flag");
         fail_cnt++;
      end

   // ------------------------------------------------
   // Reset state and sticky overflow
   // ------------------------------------------------
   reset_state_a: assert property (@(posedge clk_e)
         rst_i |=> (!aq_valid_i && !mcb_ce_i && !overflow_i && state_i == SCH_IDLE))
      else begin
         $error("outputs not in their reset state after reset");
         fail_cnt++;
      end

   ovf_sticky_a: assert property (@(posedge clk_e) disable iff (rst_i) overflow_i |=> overflow_i)
      else begin
         $error("overflow flag cleared without reset");
         fail_cnt++;
      end

endmodule

`default_nettype wire

// File: testbench/capture_mon.sv
`default_nettype none

`include "capture_params.svh"

module capture_mon import capture_pkg::*; import mcb_pkg::*; (
   input  wire                  clk_e,
   input  wire                  rst_i,
   input  wire                  aq_ce_i,
   input  wire                  vx_ce_i,
   input  wire                  aq_debug_i,
   input  wire                  aq_shift_i,
   input  wire                  aq_count_i,
   input  ax_sample_t           ax_data_i,
   input  ax_sample_t           cap_data_i,    // DUT ax_data_o
   input  wire                  cap_valid_i,   // DUT aq_valid_o
   input  wire                  mcb_ce_i,
   input  wire                  mcb_wr_i,
   input  wire [`MCB_ABITS-1:0] mcb_adr_i,
   input  wire [31:0]           mcb_dat_i,
   input  wire                  mcb_rdy_i,
   input  wire                  overflow_i,
   input  sched_state_t         state_i,
   input  wire                  pack_en_i,     // Word checks on, no samples dropped
   input  wire                  row_end_i,
   input  wire                  exp_ovf_i,
   output int                   err_count_o,
   output int                   bytes_left_o,  // Expected bytes not yet written
   output int                   word_count_o
);

   timeunit 1ns;
   timeprecision 1ps;

   ax_sample_t            gen_q;                // Fake generator model
   ax_sample_t            exp_data;
   logic                  exp_valid = 1'b0;
   logic                  armed     = 1'b0;     // First reset edge seen
   logic                  after_rst = 1'b0;
   logic [`MCB_ABITS-1:0] exp_adr;
   logic [7:0]            exp_bytes [$];        // Captured stream, oldest first
   logic [31:0]           exp_word;
   fake_mode_t            mode;
   int                    errs  = 0;
   int                    words = 0;

   // Shift beats count, LFSR otherwise
   function automatic fake_mode_t decode_mode(input logic shift, input logic count);
      if (shift) return FAKE_SHIFT;
      if (count) return FAKE_COUNT;
      return FAKE_LFSR;
   endfunction

   function automatic ax_sample_t start_value(input fake_mode_t m);
      case (m)
         FAKE_SHIFT: return 24'h000001;
         FAKE_COUNT: return 24'h000000;
         default:    return `LFSR_SEED;
      endcase
   endfunction

   // x^24+x^23+x^22+x^17+1, new bit at the bottom
   function automatic ax_sample_t next_pattern(input ax_sample_t v, input fake_mode_t m);
      case (m)
         FAKE_SHIFT: return {v[22:0], v[23]};
         FAKE_COUNT: return v + 24'd1;
         default:    return {v[22:0], v[23] ^ v[22] ^ v[21] ^ v[16]};
      endcase
   endfunction

   task automatic flag_mismatch(input string msg);
      errs++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
   endtask

   always @(posedge clk_e) begin
      mode = decode_mode(aq_shift_i, aq_count_i);
      // ------------------------------------------------
      // Capture register, predicted one edge earlier
      // ------------------------------------------------
      if (armed) begin
         if (cap_valid_i !== exp_valid)
            flag_mismatch($sformatf("aq_valid_o %b, expected %b", cap_valid_i, exp_valid));
         else if (exp_valid && cap_data_i !== exp_data)
            flag_mismatch($sformatf("ax_data_o %h, expected %h", cap_data_i, exp_data));
         if (after_rst && (mcb_ce_i !== 1'b0 || overflow_i !== 1'b0 || state_i !== SCH_IDLE))
            flag_mismatch("mcb_ce_o, overflow_o or tart_state_o not cleared by reset");
      end
      // Accepted memory words against the byte stream
      if (!rst_i && pack_en_i && mcb_ce_i && mcb_rdy_i) begin
         if (exp_bytes.size() < 4) begin
            flag_mismatch($sformatf("word at address %h with no captured data", mcb_adr_i));
         end else begin
            for (int i = 0; i < 4; i++) exp_word[8*i +: 8] = exp_bytes.pop_front();
            if (mcb_wr_i !== 1'b1 || mcb_adr_i !== exp_adr || mcb_dat_i !== exp_word)
               flag_mismatch($sformatf("word %0d adr %h dat %h wr %b, expected adr %h dat %h",
                  words, mcb_adr_i, mcb_dat_i, mcb_wr_i, exp_adr, exp_word));
         end
         exp_adr++;   // Wraps with the address width
         words++;
      end
      if (row_end_i && overflow_i !== exp_ovf_i)
         flag_mismatch($sformatf("overflow_o %b, expected %b", overflow_i, exp_ovf_i));
      // Prediction for the next edge
      if (rst_i) begin
         armed     = 1'b1;
         after_rst = 1'b1;
         exp_valid = 1'b0;
         gen_q     = start_value(mode);
         exp_adr   = '0;
         words     = 0;
         exp_bytes.delete();
      end else begin
         after_rst = 1'b0;
         exp_valid = aq_ce_i | vx_ce_i;
         if (exp_valid) begin
            exp_data = aq_debug_i ? gen_q : ax_data_i;
            if (aq_debug_i) gen_q = next_pattern(gen_q, mode);
            for (int i = 0; i < 3; i++) exp_bytes.push_back(exp_data[8*i +: 8]);   // LSB first
         end
      end
      err_count_o  <= errs;
      bytes_left_o <= exp_bytes.size();
      word_count_o <= words;
   end

endmodule

`default_nettype wire

// File: testbench/capture_tb.sv
`default_nettype none

`include "capture_params.svh"

module capture_tb import capture_pkg::*; import mcb_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int RESET_CYCLES = 16;
   localparam int SEND_LIMIT   = 5000;   // Cycles to issue one row's samples
   localparam int DRAIN_LIMIT  = 2000;   // Cycles for the last words to leave
   localparam int NROWS        = 7;

   localparam logic [1:0] SRC_REAL  = 2'd0;
   localparam logic [1:0] SRC_LFSR  = 2'd1;
   localparam logic [1:0] SRC_SHIFT = 2'd2;
   localparam logic [1:0] SRC_COUNT = 2'd3;

   typedef struct packed {
      logic [1:0]  src;       // Sample source
      logic [15:0] nsamp;     // Samples to capture
      logic [7:0]  en_pct;    // Enable density in percent
      logic [7:0]  rdy_pct;   // mcb_rdy_i density in percent
      logic        exp_ovf;
   } row_t;

   // ------------------------------------------------
   // Stimulus table
   // ------------------------------------------------
   localparam row_t ROWS [NROWS] = '{
      '{SRC_REAL,  16'd60, 8'd35,  8'd100, 1'b0},   // Plain capture
      '{SRC_COUNT, 16'd40, 8'd35,  8'd100, 1'b0},
      '{SRC_SHIFT, 16'd40, 8'd35,  8'd100, 1'b0},   // Wraps past bit 23
      '{SRC_LFSR,  16'd60, 8'd35,  8'd100, 1'b0},
      '{SRC_REAL,  16'd40, 8'd100, 8'd0,   1'b1},   // Controller never ready
      '{SRC_REAL,  16'd80, 8'd25,  8'd50,  1'b0},   // Random back-pressure
      '{SRC_LFSR,  16'd80, 8'd25,  8'd40,  1'b0}
   };

   logic                  clk_e = 1'b0;
   logic                  rst_i;
   logic                  aq_ce_i;
   logic                  vx_ce_i;
   logic                  aq_debug_i;
   logic                  aq_shift_i;
   logic                  aq_count_i;
   ax_sample_t            ax_data_i;
   ax_sample_t            ax_data_o;
   logic                  aq_valid_o;
   logic                  mcb_ce_o;
   logic                  mcb_wr_o;
   logic [`MCB_ABITS-1:0] mcb_adr_o;
   logic [31:0]           mcb_dat_o;
   logic                  mcb_rdy_i;
   logic                  overflow_o;
   sched_state_t          tart_state_o;
   logic                  pack_en;
   logic                  row_end;
   logic                  exp_ovf;
   int                    err_count;
   int                    bytes_left;
   int                    word_count;
   integer                seed = 32'h2c54_dda8;

   always #10 clk_e = ~clk_e;   // 20 ns period

   capture_top capture_top_inst (.*);

   capture_mon mon_inst (
      .clk_e        (clk_e),
      .rst_i        (rst_i),
      .aq_ce_i      (aq_ce_i),
      .vx_ce_i      (vx_ce_i),
      .aq_debug_i   (aq_debug_i),
      .aq_shift_i   (aq_shift_i),
      .aq_count_i   (aq_count_i),
      .ax_data_i    (ax_data_i),
      .cap_data_i   (ax_data_o),
      .cap_valid_i  (aq_valid_o),
      .mcb_ce_i     (mcb_ce_o),
      .mcb_wr_i     (mcb_wr_o),
      .mcb_adr_i    (mcb_adr_o),
      .mcb_dat_i    (mcb_dat_o),
      .mcb_rdy_i    (mcb_rdy_i),
      .overflow_i   (overflow_o),
      .state_i      (tart_state_o),
      .pack_en_i    (pack_en),
      .row_end_i    (row_end),
      .exp_ovf_i    (exp_ovf),
      .err_count_o  (err_count),
      .bytes_left_o (bytes_left),
      .word_count_o (word_count)
   );

   bind capture_top capture_chk chk_inst (
      .clk_e      (clk_e),
      .rst_i      (rst_i),
      .aq_valid_i (aq_valid_o),
      .mcb_ce_i   (mcb_ce_o),
      .mcb_wr_i   (mcb_wr_o),
      .mcb_adr_i  (mcb_adr_o),
      .mcb_dat_i  (mcb_dat_o),
      .mcb_rdy_i  (mcb_rdy_i),
      .overflow_i (overflow_o),
      .state_i    (tart_state_o)
   );

   function automatic logic roll_percent(input int pct);
      logic [31:0] v;
      v = $random(seed);
      return (v % 32'd100) < pct;
   endfunction

   function automatic string src_name(input logic [1:0] src);
      case (src)
         SRC_LFSR:  return "lfsr";
         SRC_SHIFT: return "shift";
         SRC_COUNT: return "count";
         default:   return "real";
      endcase
   endfunction

   initial begin
      int          npass;
      int          nfail;
      int          errs_seen;
      int          chk_fails;
      int          sent;
      int          cyc;
      logic        timed_out;
      logic        en;
      logic        row_ok;
      logic [31:0] pick;
      row_t        row;
      npass      = 0;
      nfail      = 0;
      errs_seen  = 0;
      timed_out  = 1'b0;
      rst_i      <= 1'b1;
      aq_ce_i    <= 1'b0;
      vx_ce_i    <= 1'b0;
      aq_debug_i <= 1'b0;
      aq_shift_i <= 1'b0;
      aq_count_i <= 1'b0;
      ax_data_i  <= '0;
      mcb_rdy_i  <= 1'b0;
      pack_en    <= 1'b0;
      row_end    <= 1'b0;
      exp_ovf    <= 1'b0;
      for (int r = 0; r < NROWS && !timed_out; r++) begin
         row = ROWS[r];
         // Mode is set before and held through reset
         @(posedge clk_e);
         rst_i      <= 1'b1;
         aq_debug_i <= (row.src != SRC_REAL);
         aq_shift_i <= (row.src == SRC_SHIFT);
         aq_count_i <= (row.src == SRC_COUNT);
         pack_en    <= !row.exp_ovf;
         mcb_rdy_i  <= 1'b0;
         repeat (RESET_CYCLES) @(posedge clk_e);
         rst_i <= 1'b0;
         // ------------------------------------------------
         // Issue the row's samples
         // ------------------------------------------------
         sent = 0;
         cyc  = 0;
         while (sent < int'(row.nsamp) && cyc < SEND_LIMIT) begin
            en   = roll_percent(int'(row.en_pct));
            pick = $random(seed);
            aq_ce_i   <= en & pick[0];    // Either enable captures
            vx_ce_i   <= en & !pick[0];
            ax_data_i <= ax_sample_t'($random(seed));
            mcb_rdy_i <= roll_percent(int'(row.rdy_pct));
            if (en) sent++;
            cyc++;
            @(posedge clk_e);
         end
         if (sent < int'(row.nsamp)) begin
            $display("Timeout: row %0d could not issue its samples", r);
            timed_out = 1'b1;
         end
         aq_ce_i <= 1'b0;
         vx_ce_i <= 1'b0;
         // Wait for every full word to reach the controller
         cyc = 0;
         while (!timed_out && !row.exp_ovf && cyc < DRAIN_LIMIT
                && (cyc < 3 || bytes_left >= 4 || mcb_ce_o)) begin
            @(posedge clk_e);
            mcb_rdy_i <= roll_percent(int'(row.rdy_pct));
            cyc++;
         end
         if (cyc >= DRAIN_LIMIT) begin
            $display("Timeout: row %0d, memory words did not drain", r);
            timed_out = 1'b1;
         end
         if (!timed_out) begin
            exp_ovf <= row.exp_ovf;
            row_end <= 1'b1;
            @(posedge clk_e);
            row_end <= 1'b0;
         end
         @(negedge clk_e);
         row_ok = !timed_out && (err_count == errs_seen);
         errs_seen = err_count;
         if (row_ok) npass++;
         else nfail++;
         $display("row %0d %s: %0d samples, %0d words, overflow %b, %s", r, src_name(row.src),
            sent, word_count, overflow_o, row_ok ? "ok" : "fail");
      end
      chk_fails = capture_top_inst.chk_inst.fail_cnt;
      $display("rows passed %0d, rows failed %0d, assertion failures %0d", npass, nfail,
         chk_fails);
      if (nfail == 0 && chk_fails == 0 && !timed_out) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
+incdir+logic
logic/capture_pkg.sv
logic/mcb_pkg.sv
logic/mcb_if.sv
logic/fake_antenna.sv
logic/antenna_capture.sv
logic/stream_fifo.sv
logic/block_scheduler.sv
logic/capture_top.sv
testbench/capture_chk.sv
testbench/capture_mon.sv
testbench/capture_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the capture testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module capture_tb -Mdir obj_dir -f tb.f

./obj_dir/Vcapture_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
   echo "run_sim: pass"
else
   echo "run_sim: fail"
   exit 1
fi
